// File: design/aw_dispatch.sv
//----------------------------
// AW dispatch
// Forwards the arbitrated AW to the master and records each
// decision once in the write order FIFO
//----------------------------
module aw_dispatch (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_mux_pkg::mst_ax_t   ax_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  axi_mux_pkg::port_idx_t idx_i,
  output axi_mux_pkg::mst_ax_t   aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output axi_mux_pkg::port_idx_t head_o,
  output logic                   empty_o,
  input  logic                   pop_i
);

  import axi_mux_pkg::*;

  aw_state_e state_q;
  aw_state_e state_d;
  logic      push;
  logic      fifo_full;

  assign aw_o = ax_i;

  //----------------------------
  // Valid lock
  //----------------------------
  always_comb begin
    state_d    = state_q;
    push       = 1'b0;
    aw_valid_o = 1'b0;
    ready_o    = 1'b0;
    case (state_q)
      AW_OPEN: begin
        // New decision only with room for its W order entry
        if (valid_i && !fifo_full) begin
          aw_valid_o = 1'b1;
          push       = 1'b1;
          if (aw_ready_i) begin
            ready_o = 1'b1;
          end else begin
            state_d = AW_HELD;
          end
        end
      end
      AW_HELD: begin
        // Already pushed, keep valid up until the master takes it
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          ready_o = 1'b1;
          state_d = AW_OPEN;
        end
      end
      default: state_d = AW_OPEN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= AW_OPEN;
    end else begin
      state_q <= state_d;
    end
  end

  w_order_fifo u_w_order_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .data_i  (idx_i),
    .pop_i   (pop_i),
    .data_o  (head_o),
    .full_o  (fifo_full),
    .empty_o (empty_o)
  );

endmodule

// File: design/ax_arbiter.sv
//----------------------------
// Address channel arbiter
// Round-robin over the slave ports with lock-in, and prefixes
// the granted port index onto the ID
//----------------------------
module ax_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  axi_mux_pkg::slv_ax_t [axi_mux_pkg::NUM_PORTS-1:0] req_i,
  input  logic                 [axi_mux_pkg::NUM_PORTS-1:0] valid_i,
  output logic                 [axi_mux_pkg::NUM_PORTS-1:0] ready_o,
  output axi_mux_pkg::mst_ax_t                              ax_o,
  output logic                                              valid_o,
  input  logic                                              ready_i,
  output axi_mux_pkg::port_idx_t                            idx_o
);

  import axi_mux_pkg::*;

  // Search starts at ptr_q, the port after the last grant
  port_idx_t ptr_q;
  logic      lock_q;
  port_idx_t lock_idx_q;
  port_idx_t sel;
  logic      found;

  //----------------------------
  // Selection
  //----------------------------
  always_comb begin
    port_idx_t cand;
    cand  = ptr_q;
    sel   = ptr_q;
    found = 1'b0;
    if (lock_q) begin
      // Held decision, the source keeps valid until ready
      sel   = lock_idx_q;
      found = valid_i[lock_idx_q];
    end else begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        cand = ptr_q + port_idx_t'(k);
        if (!found && valid_i[cand]) begin
          found = 1'b1;
          sel   = cand;
        end
      end
    end
  end

  assign valid_o     = found;
  assign idx_o       = sel;
  assign ax_o.id     = {sel, req_i[sel].id};
  assign ax_o.addr   = req_i[sel].addr;
  assign ax_o.len    = req_i[sel].len;
  assign ax_o.burst  = req_i[sel].burst;

  // Ready goes back to the granted port only
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      ready_o[i] = valid_o && ready_i && (sel == port_idx_t'(i));
    end
  end

  //----------------------------
  // Pointer and lock state
  //----------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o) begin
      if (ready_i) begin
        lock_q <= 1'b0;
        ptr_q  <= sel + port_idx_t'(1);
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

  // A stalled request must not change before it is accepted
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(ax_o))
    else $error("ax_arbiter: request changed while stalled");

endmodule

// File: design/axi_mux_pkg.sv
//----------------------------
// AXI multiplexer package
// Widths, channel structs and port bundles shared by the four-port
// multiplexer and its testbench
//----------------------------
package axi_mux_pkg;

  localparam int unsigned NUM_PORTS   = 4;
  localparam int unsigned PORT_IDX_W  = 2;
  localparam int unsigned SLV_ID_W    = 4;
  localparam int unsigned MST_ID_W    = SLV_ID_W + PORT_IDX_W;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned MAX_W_TRANS = 8;
  localparam int unsigned W_PTR_W     = $clog2(MAX_W_TRANS);

  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_W/8-1:0]   strb_t;
  typedef logic [7:0]            len_t;
  typedef logic [1:0]            burst_t;
  typedef logic [1:0]            resp_t;
  // Order FIFO pointer and fill level
  typedef logic [W_PTR_W-1:0]    w_ptr_t;
  typedef logic [W_PTR_W:0]      w_cnt_t;

  //----------------------------
  // Channel payloads
  //----------------------------
  // The ID is the first field, so a port prefix sits in the top bits
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
    burst_t  burst;
  } slv_ax_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
    burst_t  burst;
  } mst_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  //----------------------------
  // Port bundles
  //----------------------------
  typedef struct packed {
    slv_ax_t aw;
    logic    aw_valid;
    w_t      w;
    logic    w_valid;
    logic    b_ready;
    slv_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } slv_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    slv_b_t b;
    logic   b_valid;
    logic   ar_ready;
    slv_r_t r;
    logic   r_valid;
  } slv_resp_t;

  typedef struct packed {
    mst_ax_t aw;
    logic    aw_valid;
    w_t      w;
    logic    w_valid;
    logic    b_ready;
    mst_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } mst_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    mst_b_t b;
    logic   b_valid;
    logic   ar_ready;
    mst_r_t r;
    logic   r_valid;
  } mst_resp_t;

  // AW dispatch: open for a new decision, or holding one already pushed
  typedef enum logic {
    AW_OPEN,
    AW_HELD
  } aw_state_e;

endpackage

// File: design/axi_mux_top.sv
//----------------------------
// Four-port AXI multiplexer
// Slave port requests share one master port, responses return
// by the port index in the ID
//----------------------------
module axi_mux_top (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  axi_mux_pkg::slv_req_t  [axi_mux_pkg::NUM_PORTS-1:0] slv_reqs_i,
  output axi_mux_pkg::slv_resp_t [axi_mux_pkg::NUM_PORTS-1:0] slv_resps_o,
  output axi_mux_pkg::mst_req_t                               mst_req_o,
  input  axi_mux_pkg::mst_resp_t                              mst_resp_i
);

  import axi_mux_pkg::*;

  slv_ax_t [NUM_PORTS-1:0] aw_reqs;
  slv_ax_t [NUM_PORTS-1:0] ar_reqs;
  w_t      [NUM_PORTS-1:0] w_chans;
  slv_b_t  [NUM_PORTS-1:0] b_chans;
  slv_r_t  [NUM_PORTS-1:0] r_chans;
  logic    [NUM_PORTS-1:0] aw_valids, aw_readies;
  logic    [NUM_PORTS-1:0] ar_valids, ar_readies;
  logic    [NUM_PORTS-1:0] w_valids, w_readies;
  logic    [NUM_PORTS-1:0] b_valids, b_readies;
  logic    [NUM_PORTS-1:0] r_valids, r_readies;

  // Arbitrated AW towards dispatch
  mst_ax_t   aw_arb;
  logic      aw_arb_valid;
  logic      aw_arb_ready;
  port_idx_t aw_arb_idx;
  port_idx_t w_head;
  logic      w_empty;
  logic      w_pop;

  //----------------------------
  // Slave port unpacking
  //----------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_ports
    assign aw_reqs[i]              = slv_reqs_i[i].aw;
    assign aw_valids[i]            = slv_reqs_i[i].aw_valid;
    assign ar_reqs[i]              = slv_reqs_i[i].ar;
    assign ar_valids[i]            = slv_reqs_i[i].ar_valid;
    assign w_chans[i]              = slv_reqs_i[i].w;
    assign w_valids[i]             = slv_reqs_i[i].w_valid;
    assign b_readies[i]            = slv_reqs_i[i].b_ready;
    assign r_readies[i]            = slv_reqs_i[i].r_ready;
    assign slv_resps_o[i].aw_ready = aw_readies[i];
    assign slv_resps_o[i].ar_ready = ar_readies[i];
    assign slv_resps_o[i].w_ready  = w_readies[i];
    assign slv_resps_o[i].b        = b_chans[i];
    assign slv_resps_o[i].b_valid  = b_valids[i];
    assign slv_resps_o[i].r        = r_chans[i];
    assign slv_resps_o[i].r_valid  = r_valids[i];
  end

  ax_arbiter u_aw_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (aw_reqs),
    .valid_i (aw_valids),
    .ready_o (aw_readies),
    .ax_o    (aw_arb),
    .valid_o (aw_arb_valid),
    .ready_i (aw_arb_ready),
    .idx_o   (aw_arb_idx)
  );

  aw_dispatch u_aw_dispatch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ax_i       (aw_arb),
    .valid_i    (aw_arb_valid),
    .ready_o    (aw_arb_ready),
    .idx_i      (aw_arb_idx),
    .aw_o       (mst_req_o.aw),
    .aw_valid_o (mst_req_o.aw_valid),
    .aw_ready_i (mst_resp_i.aw_ready),
    .head_o     (w_head),
    .empty_o    (w_empty),
    .pop_i      (w_pop)
  );

  w_steer u_w_steer (
    .slv_w_i       (w_chans),
    .slv_w_valid_i (w_valids),
    .slv_w_ready_o (w_readies),
    .w_o           (mst_req_o.w),
    .w_valid_o     (mst_req_o.w_valid),
    .w_ready_i     (mst_resp_i.w_ready),
    .head_i        (w_head),
    .empty_i       (w_empty),
    .pop_o         (w_pop)
  );

  resp_router #(.mst_t(mst_b_t)) u_b_router (
    .mst_i       (mst_resp_i.b),
    .mst_valid_i (mst_resp_i.b_valid),
    .mst_ready_o (mst_req_o.b_ready),
    .slv_o       (b_chans),
    .slv_valid_o (b_valids),
    .slv_ready_i (b_readies)
  );

  // AR needs no ordering, the arbiter drives the master directly
  ax_arbiter u_ar_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ar_reqs),
    .valid_i (ar_valids),
    .ready_o (ar_readies),
    .ax_o    (mst_req_o.ar),
    .valid_o (mst_req_o.ar_valid),
    .ready_i (mst_resp_i.ar_ready),
    .idx_o   ()
  );

  resp_router #(.mst_t(mst_r_t)) u_r_router (
    .mst_i       (mst_resp_i.r),
    .mst_valid_i (mst_resp_i.r_valid),
    .mst_ready_o (mst_req_o.r_ready),
    .slv_o       (r_chans),
    .slv_valid_o (r_valids),
    .slv_ready_i (r_readies)
  );

endmodule

// File: design/resp_router.sv
//----------------------------
// Response router
// Sends a B or R beat to the port named by its ID prefix and
// strips that prefix
//----------------------------
module resp_router #(
  parameter type mst_t = axi_mux_pkg::mst_b_t,
  localparam int unsigned SLV_W = $bits(mst_t) - axi_mux_pkg::PORT_IDX_W
) (
  input  mst_t                                       mst_i,
  input  logic                                       mst_valid_i,
  output logic                                       mst_ready_o,
  output logic [axi_mux_pkg::NUM_PORTS-1:0][SLV_W-1:0] slv_o,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]          slv_valid_o,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]          slv_ready_i
);

  import axi_mux_pkg::*;

  // The ID leads the struct and its prefix is the top of the vector
  port_idx_t sel;

  assign sel         = mst_i[$bits(mst_t)-1 -: PORT_IDX_W];
  assign mst_ready_o = slv_ready_i[sel];

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      slv_o[i]       = mst_i[SLV_W-1:0];
      slv_valid_o[i] = mst_valid_i && (sel == port_idx_t'(i));
    end
  end

endmodule

// File: design/w_order_fifo.sv
//----------------------------
// Write order FIFO
// Circular buffer of port indices, one per granted write burst
//----------------------------
module w_order_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  axi_mux_pkg::port_idx_t data_i,
  input  logic                   pop_i,
  output axi_mux_pkg::port_idx_t data_o,
  output logic                   full_o,
  output logic                   empty_o
);

  import axi_mux_pkg::*;

  port_idx_t mem_q [MAX_W_TRANS];
  w_ptr_t    wr_ptr_q;
  w_ptr_t    rd_ptr_q;
  w_cnt_t    count_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == w_cnt_t'(MAX_W_TRANS));
  assign empty_o = (count_q == '0);

  // Storage, written at the edge of a push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  //----------------------------
  // Pointers and fill level
  //----------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        if (wr_ptr_q == w_ptr_t'(MAX_W_TRANS - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + w_ptr_t'(1);
        end
      end
      if (pop_i) begin
        if (rd_ptr_q == w_ptr_t'(MAX_W_TRANS - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + w_ptr_t'(1);
        end
      end
      // Simultaneous push and pop leave the level unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + w_cnt_t'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - w_cnt_t'(1);
      end
    end
  end

  // Dispatch and steering must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("w_order_fifo: push while full");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("w_order_fifo: pop while empty");

endmodule

// File: design/w_steer.sv
//----------------------------
// W steering
// Connects the W channel of the port at the order FIFO head
//----------------------------
module w_steer (
  input  axi_mux_pkg::w_t       [axi_mux_pkg::NUM_PORTS-1:0] slv_w_i,
  input  logic                  [axi_mux_pkg::NUM_PORTS-1:0] slv_w_valid_i,
  output logic                  [axi_mux_pkg::NUM_PORTS-1:0] slv_w_ready_o,
  output axi_mux_pkg::w_t                                    w_o,
  output logic                                               w_valid_o,
  input  logic                                               w_ready_i,
  input  axi_mux_pkg::port_idx_t                             head_i,
  input  logic                                               empty_i,
  output logic                                               pop_o
);

  import axi_mux_pkg::*;

  assign w_o = slv_w_i[head_i];

  always_comb begin
    w_valid_o     = 1'b0;
    slv_w_ready_o = '0;
    pop_o         = 1'b0;
    if (!empty_i) begin
      w_valid_o             = slv_w_valid_i[head_i];
      slv_w_ready_o[head_i] = w_ready_i;
      // Last beat of the burst moves the next decision to the head
      pop_o = slv_w_valid_i[head_i] && w_ready_i && slv_w_i[head_i].last;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the AXI multiplexer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_axi_mux \
  -Mdir obj_dir \
  -o sim_axi_mux

./obj_dir/sim_axi_mux > sim.log
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: verif/tb_axi_mux_model.svh
//----------------------------
// AXI multiplexer reference model
// Expected request queues, write order and response bookkeeping
//----------------------------
`ifndef TB_AXI_MUX_MODEL_SVH
`define TB_AXI_MUX_MODEL_SVH

// Requests in the order each slave port issued them
slv_ax_t aw_exp [NUM_PORTS][$];
slv_ax_t ar_exp [NUM_PORTS][$];
slv_ax_t rd_exp [NUM_PORTS][$];
// Master AW handshakes still waiting for their W burst
mst_ax_t w_order [$];
// Responses the master-side responder still has to send
mst_id_t b_pend [$];
mst_ax_t r_pend [$];
int      w_bursts [NUM_PORTS];
int      r_beat_slv [NUM_PORTS];
int      w_beat;
int      aw_acc;
int      w_done;
int      b_cnt;
int      r_cnt;
int      errors;
int      timeouts;

task automatic report_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
  errors++;
  $display("Error %s: expected %0h, actual %0h", name, exp, act);
endtask

// W beat payload built from port, burst number and beat number
function automatic data_t beat_data(input int p, input int n, input int b);
  return {8'(p), 8'(n), 8'(b), 8'hA5};
endfunction

// Byte strobes that change with port and beat
function automatic strb_t beat_strb(input int p, input int b);
  return strb_t'(p + 2 * b + 1);
endfunction

task automatic check_master_ax(input bit is_ar, input mst_ax_t ax);
  port_idx_t p;
  slv_ax_t   e;
  p = ax.id[MST_ID_W-1 -: PORT_IDX_W];
  if ((is_ar && ar_exp[p].size() == 0) || (!is_ar && aw_exp[p].size() == 0)) begin
    errors++;
    $display("Master request from port %0d that the port never issued", p);
  end else begin
    if (is_ar) begin
      e = ar_exp[p].pop_front();
    end else begin
      e = aw_exp[p].pop_front();
    end
    if (ax.id !== {p, e.id}) report_mismatch("ax_id", 64'({p, e.id}), 64'(ax.id));
    if (ax.addr !== e.addr) report_mismatch("ax_addr", 64'(e.addr), 64'(ax.addr));
    if (ax.len !== e.len) report_mismatch("ax_len", 64'(e.len), 64'(ax.len));
    if (ax.burst !== e.burst) report_mismatch("ax_burst", 64'(e.burst), 64'(ax.burst));
  end
endtask

task automatic check_master_w(input w_t w);
  mst_ax_t   h;
  port_idx_t p;
  if (w_order.size() == 0) begin
    errors++;
    $display("Master W beat without a preceding AW");
  end else begin
    h = w_order[0];
    p = h.id[MST_ID_W-1 -: PORT_IDX_W];
    if (w.data !== beat_data(p, w_bursts[p], w_beat))
      report_mismatch("w_data", 64'(beat_data(p, w_bursts[p], w_beat)), 64'(w.data));
    if (w.strb !== beat_strb(p, w_beat))
      report_mismatch("w_strb", 64'(beat_strb(p, w_beat)), 64'(w.strb));
    if (w.last !== (w_beat == int'(h.len)))
      report_mismatch("w_last", 64'(w_beat == int'(h.len)), 64'(w.last));
    w_beat++;
    if (w.last) begin
      void'(w_order.pop_front());
      b_pend.push_back(h.id);
      w_bursts[p]++;
      w_beat = 0;
      w_done++;
    end
  end
endtask

task automatic check_slave_r(input int p, input slv_r_t r);
  slv_ax_t e;
  int      beat;
  if (rd_exp[p].size() == 0) begin
    errors++;
    $display("R beat at port %0d without an open read", p);
  end else begin
    e    = rd_exp[p][0];
    beat = r_beat_slv[p];
    if (r.data !== data_t'(e.addr + addr_t'(beat)))
      report_mismatch("r_data", 64'(e.addr + addr_t'(beat)), 64'(r.data));
    if (r.id !== e.id) report_mismatch("r_id", 64'(e.id), 64'(r.id));
    if (r.last !== (beat == int'(e.len)))
      report_mismatch("r_last", 64'(beat == int'(e.len)), 64'(r.last));
    r_beat_slv[p]++;
    if (r.last) begin
      void'(rd_exp[p].pop_front());
      r_beat_slv[p] = 0;
      r_cnt++;
    end
  end
endtask

`endif

// File: verif/tb_axi_mux.sv
//----------------------------
// AXI multiplexer testbench
// Random traffic on four slave ports, a random master-side
// responder and checks against the reference model
//----------------------------
module tb_axi_mux;

  timeunit 1ns;
  timeprecision 100ps;

  import axi_mux_pkg::*;

  localparam int N_WR    = 12;
  localparam int N_RD    = 8;
  localparam int TIMEOUT = 3000;
  localparam int STALL   = 300;

  logic                    clk_i;
  logic                    rst_n_i;
  slv_req_t  [NUM_PORTS-1:0] slv_reqs;
  slv_resp_t [NUM_PORTS-1:0] slv_resps;
  mst_req_t                mst_req;
  mst_resp_t               mst_resp;

  int      seed = 60;
  logic    w_stall;
  logic    b_fire;
  logic    r_fire;
  int      r_beat;
  int      ports_done;
  logic    aw_stalled;
  logic    ar_stalled;
  mst_ax_t aw_last;
  mst_ax_t ar_last;
  int      others [2][NUM_PORTS];
  len_t    w_lens [NUM_PORTS][$];

  `include "tb_axi_mux_model.svh"

  axi_mux_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slv_reqs_i  (slv_reqs),
    .slv_resps_o (slv_resps),
    .mst_req_o   (mst_req),
    .mst_resp_i  (mst_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic ready_of(input int p, input int ch);
    case (ch)
      0: return slv_resps[p].aw_ready;
      1: return slv_resps[p].w_ready;
      default: return slv_resps[p].ar_ready;
    endcase
  endfunction

  // Returns 1 ns after the edge that completes the handshake
  task automatic wait_handshake(input int p, input int ch, input string what);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!ready_of(p, ch) && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= TIMEOUT) begin
      timeouts++;
      $display("Timeout: port %0d never saw %s", p, what);
    end
    @(posedge clk_i);
    #1;
  endtask

  //----------------------------
  // Slave port traffic
  //----------------------------
  task automatic issue_ax(input int p, input bit is_ar, input int n_req);
    slv_ax_t ax;
    int      r;
    for (int n = 0; n < n_req; n++) begin
      r = $random(seed);
      repeat (r[1:0]) begin
        @(posedge clk_i);
        #1;
      end
      ax.id    = slv_id_t'(r[5:2]);
      ax.len   = len_t'(r[7:6]);
      ax.burst = burst_t'(r[8]);
      ax.addr  = addr_t'($random(seed));
      if (is_ar) begin
        ar_exp[p].push_back(ax);
        rd_exp[p].push_back(ax);
        slv_reqs[p].ar       = ax;
        slv_reqs[p].ar_valid = 1'b1;
        wait_handshake(p, 2, "ar_ready");
        slv_reqs[p].ar_valid = 1'b0;
      end else begin
        aw_exp[p].push_back(ax);
        slv_reqs[p].aw       = ax;
        slv_reqs[p].aw_valid = 1'b1;
        wait_handshake(p, 0, "aw_ready");
        slv_reqs[p].aw_valid = 1'b0;
        w_lens[p].push_back(ax.len);
      end
    end
    ports_done++;
  endtask

  task automatic send_writes(input int p);
    len_t len;
    int   t;
    for (int n = 0; n < N_WR; n++) begin
      t = 0;
      while (w_lens[p].size() == 0 && t < TIMEOUT) begin
        @(posedge clk_i);
        #1;
        t++;
      end
      if (t >= TIMEOUT) begin
        timeouts++;
        $display("Timeout: port %0d has no accepted AW for its W burst", p);
        break;
      end
      len = w_lens[p].pop_front();
      for (int b = 0; b <= int'(len); b++) begin
        slv_reqs[p].w.data  = beat_data(p, n, b);
        slv_reqs[p].w.strb  = beat_strb(p, b);
        slv_reqs[p].w.last  = (b == int'(len));
        slv_reqs[p].w_valid = 1'b1;
        wait_handshake(p, 1, "w_ready");
        slv_reqs[p].w_valid = 1'b0;
      end
    end
    ports_done++;
  endtask

  //----------------------------
  // Master-side responder
  //----------------------------
  initial begin
    int r;
    mst_resp = '0;
    r_beat   = 0;
    forever begin
      @(posedge clk_i);
      #1;
      r = $random(seed);
      mst_resp.aw_ready = r[0];
      mst_resp.ar_ready = r[1];
      mst_resp.w_ready  = r[2] && !w_stall;
      // Slave ports take responses at random
      for (int i = 0; i < NUM_PORTS; i++) begin
        slv_reqs[i].b_ready = r[8 + i];
        slv_reqs[i].r_ready = r[12 + i];
      end
      if (b_fire) mst_resp.b_valid = 1'b0;
      if (!mst_resp.b_valid && b_pend.size() > 0) begin
        mst_resp.b.id    = b_pend.pop_front();
        mst_resp.b.resp  = resp_t'(r[5:4]);
        mst_resp.b_valid = 1'b1;
      end
      if (r_fire) begin
        if (mst_resp.r.last) begin
          void'(r_pend.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
        mst_resp.r_valid = 1'b0;
      end
      if (!mst_resp.r_valid && r_pend.size() > 0) begin
        mst_resp.r.id    = r_pend[0].id;
        mst_resp.r.data  = data_t'(r_pend[0].addr + addr_t'(r_beat));
        mst_resp.r.resp  = resp_t'(r[7:6]);
        mst_resp.r.last  = (r_beat == int'(r_pend[0].len));
        mst_resp.r_valid = 1'b1;
      end
    end
  end

  //----------------------------
  // Monitor at the falling edge
  //----------------------------
  // No port may wait longer than NUM_PORTS-1 grants to others
  task automatic count_grant(input int ch, input int g);
    logic v;
    for (int i = 0; i < NUM_PORTS; i++) begin
      v = (ch == 0) ? slv_reqs[i].aw_valid : slv_reqs[i].ar_valid;
      if (i == g || !v) begin
        others[ch][i] = 0;
      end else begin
        others[ch][i]++;
        if (others[ch][i] > NUM_PORTS - 1) begin
          errors++;
          $display("Port %0d starved on channel %0d by other grants", i, ch);
        end
      end
    end
  endtask

  task automatic check_routes();
    port_idx_t              p;
    logic [NUM_PORTS-1:0]   bv;
    logic [NUM_PORTS-1:0]   rv;
    slv_b_t                 b_exp;
    slv_r_t                 r_exp;
    for (int i = 0; i < NUM_PORTS; i++) begin
      bv[i] = slv_resps[i].b_valid;
      rv[i] = slv_resps[i].r_valid;
    end
    if (mst_resp.b_valid) begin
      p          = mst_resp.b.id[MST_ID_W-1 -: PORT_IDX_W];
      b_exp.id   = mst_resp.b.id[SLV_ID_W-1:0];
      b_exp.resp = mst_resp.b.resp;
      if (bv !== (4'b1 << p)) report_mismatch("b_route", 64'(4'b1 << p), 64'(bv));
      if (slv_resps[p].b !== b_exp)
        report_mismatch("b_payload", 64'(b_exp), 64'(slv_resps[p].b));
      if (mst_req.b_ready !== slv_reqs[p].b_ready)
        report_mismatch("b_ready", 64'(slv_reqs[p].b_ready), 64'(mst_req.b_ready));
    end else if (bv !== '0) begin
      report_mismatch("b_idle", 64'(0), 64'(bv));
    end
    if (mst_resp.r_valid) begin
      p          = mst_resp.r.id[MST_ID_W-1 -: PORT_IDX_W];
      r_exp.id   = mst_resp.r.id[SLV_ID_W-1:0];
      r_exp.data = mst_resp.r.data;
      r_exp.resp = mst_resp.r.resp;
      r_exp.last = mst_resp.r.last;
      if (rv !== (4'b1 << p)) report_mismatch("r_route", 64'(4'b1 << p), 64'(rv));
      if (slv_resps[p].r !== r_exp)
        report_mismatch("r_payload", 64'(r_exp), 64'(slv_resps[p].r));
      if (mst_req.r_ready !== slv_reqs[p].r_ready)
        report_mismatch("r_ready", 64'(slv_reqs[p].r_ready), 64'(mst_req.r_ready));
    end else if (rv !== '0) begin
      report_mismatch("r_idle", 64'(0), 64'(rv));
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      b_fire = mst_resp.b_valid && mst_req.b_ready;
      r_fire = mst_resp.r_valid && mst_req.r_ready;
      if (aw_stalled && (!mst_req.aw_valid || mst_req.aw !== aw_last))
        report_mismatch("aw_stable", 64'(aw_last), 64'(mst_req.aw));
      if (ar_stalled && (!mst_req.ar_valid || mst_req.ar !== ar_last))
        report_mismatch("ar_stable", 64'(ar_last), 64'(mst_req.ar));
      aw_stalled = mst_req.aw_valid && !mst_resp.aw_ready;
      ar_stalled = mst_req.ar_valid && !mst_resp.ar_ready;
      aw_last    = mst_req.aw;
      ar_last    = mst_req.ar;
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        check_master_ax(1'b0, mst_req.aw);
        w_order.push_back(mst_req.aw);
        aw_acc++;
        count_grant(0, int'(mst_req.aw.id[MST_ID_W-1 -: PORT_IDX_W]));
      end
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        check_master_ax(1'b1, mst_req.ar);
        r_pend.push_back(mst_req.ar);
        count_grant(1, int'(mst_req.ar.id[MST_ID_W-1 -: PORT_IDX_W]));
      end
      if (mst_req.w_valid && mst_resp.w_ready) check_master_w(mst_req.w);
      if (aw_acc > w_done + int'(MAX_W_TRANS))
        report_mismatch("aw_outstanding", 64'(w_done + int'(MAX_W_TRANS)), 64'(aw_acc));
      check_routes();
      if (b_fire) b_cnt++;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (slv_resps[i].r_valid && slv_reqs[i].r_ready) check_slave_r(i, slv_resps[i].r);
      end
    end
  end

  //----------------------------
  // Sequence
  //----------------------------
  initial begin
    int t;
    slv_reqs   = '0;
    rst_n_i    = 1'b0;
    w_stall    = 1'b1;
    b_fire     = 1'b0;
    r_fire     = 1'b0;
    aw_stalled = 1'b0;
    ar_stalled = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_reqs[p].b_ready = 1'b1;
      slv_reqs[p].r_ready = 1'b1;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      fork
        automatic int q = p;
        issue_ax(q, 1'b0, N_WR);
        send_writes(q);
        issue_ax(q, 1'b1, N_RD);
      join_none
    end
    // W held off first so the order FIFO fills up
    repeat (STALL) @(posedge clk_i);
    #1;
    w_stall = 1'b0;
    t = 0;
    while ((ports_done < 3 * NUM_PORTS || b_cnt < NUM_PORTS * N_WR ||
            r_cnt < NUM_PORTS * N_RD) && t < 4 * TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (t >= 4 * TIMEOUT) begin
      timeouts++;
      $display("Timeout: traffic did not complete, %0d B and %0d reads seen", b_cnt, r_cnt);
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verif
design/axi_mux_pkg.sv
design/ax_arbiter.sv
design/w_order_fifo.sv
design/aw_dispatch.sv
design/w_steer.sv
design/resp_router.sv
design/axi_mux_top.sv
verif/tb_axi_mux.sv
